//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/10ps
TOP        = mips_control_tb
FILELIST   = mips_control.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Done: errors found
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended early"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/ctrl_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decode (
        input  wire ctrl_pkg::op_e       op,
        input  wire ctrl_pkg::funct_e    funct,
        output ctrl_pkg::instr_kind_e    kind
);
        import ctrl_pkg::*;

        always_comb begin
                case (op)
                        OP_RTYPE: begin
                                case (funct)
                                        FN_ADD:   kind = KIND_ADD;
                                        FN_SUB:   kind = KIND_SUB;
                                        FN_AND:   kind = KIND_AND;
                                        FN_BREAK: kind = KIND_BREAK;
                                        default:  kind = KIND_ILLEGAL;
                                endcase
                        end
                        OP_ADDI:  kind = KIND_ADDI;
                        OP_ADDIU: kind = KIND_ADDIU;
                        OP_BEQ:   kind = KIND_BEQ;
                        OP_BNE:   kind = KIND_BNE;
                        OP_LW:    kind = KIND_LW;
                        OP_SW:    kind = KIND_SW;
                        OP_J:     kind = KIND_J;
                        OP_JAL:   kind = KIND_JAL;
                        default:  kind = KIND_ILLEGAL;  // Unknown opcode traps
                endcase
        end

endmodule

`default_nettype wire

//--- design/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field widths
`define CTRL_OP_W 6
`define CTRL_FUNCT_W 6

// Step counter inside a multicycle state
`define CTRL_STEP_W 2

// Memory read cycles before the fetch write step
`define CTRL_FETCH_STEPS 3

// Address and read cycles of a load or store
`define CTRL_MEM_STEPS 3

// Cycles spent reading the exception vector
`define CTRL_EXC_STEPS 2

`endif

//--- design/ctrl_outputs.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_outputs (
        input  wire ctrl_pkg::ctrl_state_e    state,
        input  wire [`CTRL_STEP_W-1:0]        step,
        output ctrl_pkg::pc_src_e             pc_src,
        output ctrl_pkg::a_src_e              alu_src_a,
        output ctrl_pkg::b_src_e              alu_src_b,
        output ctrl_pkg::alu_op_e             alu_op,
        output ctrl_pkg::iord_e               iord,
        output ctrl_pkg::load_size_e          load_ctrl,
        output ctrl_pkg::reg_dst_e            bank_write_reg,
        output ctrl_pkg::reg_data_e           bank_write_data,
        output logic                          wr,
        output logic                          ir_write,
        output logic                          pc_write,
        output logic                          bank_write,
        output logic                          epc_write,
        output logic                          a_write,
        output logic                          b_write,
        output logic                          alu_out_write,
        output logic                          mem_reg_write
);
        import ctrl_pkg::*;

        always_comb begin
                pc_src          = PC_SRC_ALU_RESULT;
                alu_src_a       = A_SRC_PC;
                alu_src_b       = B_SRC_B;
                alu_op          = ALU_NONE;
                iord            = IORD_PC;
                load_ctrl       = LOAD_WORD;
                bank_write_reg  = REG_DST_RT;
                bank_write_data = REG_DATA_ALU_OUT;
                wr              = 1'b0;         // Read unless storing
                ir_write        = 1'b0;
                pc_write        = 1'b0;
                bank_write      = 1'b0;
                epc_write       = 1'b0;
                a_write         = 1'b0;
                b_write         = 1'b0;
                alu_out_write   = 1'b0;
                mem_reg_write   = 1'b0;

                case (state)
                        ST_FETCH: begin
                                alu_src_b = B_SRC_FOUR;         // PC + 4
                                alu_op    = ALU_ADD;
                                if (step == `CTRL_FETCH_STEPS) begin
                                        ir_write = 1'b1;
                                        pc_write = 1'b1;
                                end
                        end
                        ST_DECODE: begin
                                if (step == 0) begin
                                        // Branch target ahead of the compare
                                        alu_src_b     = B_SRC_BRANCH_OFFSET;
                                        alu_op        = ALU_ADD;
                                        a_write       = 1'b1;
                                        b_write       = 1'b1;
                                        alu_out_write = 1'b1;
                                end
                        end
                        ST_ADD, ST_SUB, ST_AND: begin
                                if (step == 0) begin
                                        alu_src_a     = A_SRC_A;
                                        alu_op        = (state == ST_ADD) ? ALU_ADD :
                                                        (state == ST_SUB) ? ALU_SUB : ALU_AND;
                                        alu_out_write = 1'b1;
                                end else begin
                                        bank_write     = 1'b1;
                                        bank_write_reg = REG_DST_RD;
                                end
                        end
                        ST_ADDI, ST_ADDIU: begin
                                alu_src_a     = A_SRC_A;
                                alu_src_b     = B_SRC_IMM;
                                alu_op        = ALU_ADD;
                                alu_out_write = 1'b1;
                        end
                        ST_IMM_WRITE: bank_write = 1'b1;        // rt from ALU_OUT
                        ST_BEQ, ST_BNE: begin
                                alu_src_a = A_SRC_A;
                                alu_op    = ALU_CMP;
                        end
                        ST_BRANCH_WRITE: begin
                                pc_src   = PC_SRC_ALU_OUT;
                                pc_write = 1'b1;
                        end
                        ST_MEM: begin
                                if (step == 0) begin
                                        alu_src_a     = A_SRC_A;
                                        alu_src_b     = B_SRC_IMM;
                                        alu_op        = ALU_ADD;
                                        alu_out_write = 1'b1;
                                end else begin
                                        iord = IORD_ALU_OUT;
                                end
                                if (step == `CTRL_MEM_STEPS) mem_reg_write = 1'b1;
                        end
                        ST_LOAD: begin
                                bank_write      = 1'b1;
                                bank_write_data = REG_DATA_MEM;
                        end
                        ST_STORE: begin
                                wr   = 1'b1;
                                iord = IORD_ALU_OUT;
                        end
                        ST_JAL: begin
                                bank_write      = 1'b1;         // Return address
                                bank_write_reg  = REG_DST_RA;
                                bank_write_data = REG_DATA_PC;
                        end
                        ST_J: begin
                                pc_src   = PC_SRC_JUMP;
                                pc_write = 1'b1;
                        end
                        ST_EXC_ILLEGAL, ST_EXC_OVERFLOW: begin
                                if (step < `CTRL_EXC_STEPS) begin
                                        // EPC gets PC - 4 while the vector is read
                                        alu_src_b     = B_SRC_FOUR;
                                        alu_op        = ALU_SUB;
                                        epc_write     = 1'b1;
                                        mem_reg_write = 1'b1;
                                        iord          = (state == ST_EXC_ILLEGAL) ?
                                                        IORD_EXC_ILLEGAL : IORD_EXC_OVERFLOW;
                                end else begin
                                        load_ctrl = LOAD_BYTE;
                                        pc_src    = PC_SRC_EXC_LOAD;
                                        pc_write  = 1'b1;
                                end
                        end
                        default: ;      // BREAK stays idle
                endcase
        end

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

`include "ctrl_defs.svh"

package ctrl_pkg;

        typedef enum logic [`CTRL_OP_W-1:0] {
                OP_RTYPE = 6'h00,
                OP_J     = 6'h02,
                OP_JAL   = 6'h03,
                OP_BEQ   = 6'h04,
                OP_BNE   = 6'h05,
                OP_ADDI  = 6'h08,
                OP_ADDIU = 6'h09,
                OP_LW    = 6'h23,
                OP_SW    = 6'h2B
        } op_e;

        typedef enum logic [`CTRL_FUNCT_W-1:0] {
                FN_BREAK = 6'h0D,
                FN_ADD   = 6'h20,
                FN_SUB   = 6'h22,
                FN_AND   = 6'h24
        } funct_e;

        typedef enum logic [3:0] {
                KIND_ADD, KIND_SUB, KIND_AND, KIND_BREAK,
                KIND_ADDI, KIND_ADDIU, KIND_BEQ, KIND_BNE,
                KIND_LW, KIND_SW, KIND_J, KIND_JAL,
                KIND_ILLEGAL
        } instr_kind_e;

        typedef enum logic [4:0] {
                ST_FETCH, ST_DECODE,
                ST_ADD, ST_SUB, ST_AND,
                ST_ADDI, ST_ADDIU, ST_IMM_WRITE,
                ST_BEQ, ST_BNE, ST_BRANCH_WRITE,
                ST_MEM, ST_LOAD, ST_STORE,
                ST_JAL, ST_J, ST_BREAK,
                ST_EXC_ILLEGAL, ST_EXC_OVERFLOW
        } ctrl_state_e;

        typedef enum logic [2:0] {
                ALU_NONE = 3'd0,
                ALU_ADD  = 3'd1,
                ALU_SUB  = 3'd2,
                ALU_AND  = 3'd3,
                ALU_CMP  = 3'd7
        } alu_op_e;

        typedef enum logic [1:0] {A_SRC_PC = 2'd0, A_SRC_A = 2'd1} a_src_e;

        typedef enum logic [1:0] {
                B_SRC_B = 2'd0, B_SRC_FOUR = 2'd1, B_SRC_IMM = 2'd2, B_SRC_BRANCH_OFFSET = 2'd3
        } b_src_e;

        typedef enum logic [1:0] {
                PC_SRC_ALU_RESULT = 2'd0, PC_SRC_ALU_OUT = 2'd1,
                PC_SRC_JUMP = 2'd2, PC_SRC_EXC_LOAD = 2'd3
        } pc_src_e;

        // Memory address select with the two cause vectors for exceptions
        typedef enum logic [2:0] {
                IORD_PC = 3'd0, IORD_ALU_OUT = 3'd1,
                IORD_EXC_ILLEGAL = 3'd3, IORD_EXC_OVERFLOW = 3'd4
        } iord_e;

        typedef enum logic [2:0] {REG_DST_RT = 3'd0, REG_DST_RD = 3'd1, REG_DST_RA = 3'd4} reg_dst_e;

        typedef enum logic [2:0] {
                REG_DATA_ALU_OUT = 3'd0, REG_DATA_MEM = 3'd1, REG_DATA_PC = 3'd6
        } reg_data_e;

        typedef enum logic [1:0] {LOAD_WORD = 2'd0, LOAD_BYTE = 2'd2} load_size_e;

endpackage

`default_nettype wire

//--- design/ctrl_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_sequencer (
        input  wire                           clk,
        input  wire                           reset,
        input  wire ctrl_pkg::instr_kind_e    kind,
        input  wire                           overflow,
        input  wire                           eq,
        output ctrl_pkg::ctrl_state_e         state,
        output logic [`CTRL_STEP_W-1:0]       step
);
        import ctrl_pkg::*;

        ctrl_state_e next_state;

        always_comb begin
                next_state = state;
                case (state)
                        ST_FETCH: if (step == `CTRL_FETCH_STEPS) next_state = ST_DECODE;
                        ST_DECODE: begin
                                if (step == 1) begin
                                        case (kind)
                                                KIND_ADD:   next_state = ST_ADD;
                                                KIND_SUB:   next_state = ST_SUB;
                                                KIND_AND:   next_state = ST_AND;
                                                KIND_BREAK: next_state = ST_BREAK;
                                                KIND_ADDI:  next_state = ST_ADDI;
                                                KIND_ADDIU: next_state = ST_ADDIU;
                                                KIND_BEQ:   next_state = ST_BEQ;
                                                KIND_BNE:   next_state = ST_BNE;
                                                KIND_LW,
                                                KIND_SW:    next_state = ST_MEM;
                                                KIND_J:     next_state = ST_J;
                                                KIND_JAL:   next_state = ST_JAL;
                                                default:    next_state = ST_EXC_ILLEGAL;
                                        endcase
                                end
                        end
                        // Overflow is caught before the write step so no bank write leaks out
                        ST_ADD, ST_SUB: begin
                                if (step == 0 && overflow)
                                        next_state = ST_EXC_OVERFLOW;
                                else if (step == 1)
                                        next_state = ST_FETCH;
                        end
                        ST_AND:   if (step == 1) next_state = ST_FETCH;
                        ST_ADDI:  next_state = overflow ? ST_EXC_OVERFLOW : ST_IMM_WRITE;
                        ST_ADDIU: next_state = ST_IMM_WRITE;
                        ST_BEQ:   next_state = eq ? ST_BRANCH_WRITE : ST_FETCH;
                        ST_BNE:   next_state = eq ? ST_FETCH : ST_BRANCH_WRITE;
                        ST_MEM: begin
                                if (step == `CTRL_MEM_STEPS)
                                        next_state = (kind == KIND_SW) ? ST_STORE : ST_LOAD;
                        end
                        ST_JAL:   next_state = ST_J;
                        ST_IMM_WRITE, ST_BRANCH_WRITE,
                        ST_LOAD, ST_STORE, ST_J: next_state = ST_FETCH;
                        ST_BREAK: next_state = ST_BREAK;        // Only reset leaves
                        ST_EXC_ILLEGAL, ST_EXC_OVERFLOW: begin
                                if (step == `CTRL_EXC_STEPS) next_state = ST_FETCH;
                        end
                        default:  next_state = ST_FETCH;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ST_FETCH;
                        step  <= '0;
                end else begin
                        state <= next_state;
                        if (next_state != state)
                                step <= '0;
                        else if (state != ST_BREAK)
                                step <= step + 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- design/mips_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_defs.svh"

module mips_control (
        input  wire                      clk,
        input  wire                      reset,
        input  wire ctrl_pkg::op_e       op,
        input  wire ctrl_pkg::funct_e    funct,
        input  wire                      overflow,
        input  wire                      eq,
        output ctrl_pkg::pc_src_e        pc_src,
        output ctrl_pkg::a_src_e         alu_src_a,
        output ctrl_pkg::b_src_e         alu_src_b,
        output ctrl_pkg::alu_op_e        alu_op,
        output ctrl_pkg::iord_e          iord,
        output ctrl_pkg::load_size_e     load_ctrl,
        output ctrl_pkg::reg_dst_e       bank_write_reg,
        output ctrl_pkg::reg_data_e      bank_write_data,
        output logic                     wr,
        output logic                     ir_write,
        output logic                     pc_write,
        output logic                     bank_write,
        output logic                     epc_write,
        output logic                     a_write,
        output logic                     b_write,
        output logic                     alu_out_write,
        output logic                     mem_reg_write
);
        import ctrl_pkg::*;

        instr_kind_e             kind;
        ctrl_state_e             state;
        logic [`CTRL_STEP_W-1:0] step;

        ctrl_decode u_decode (
                .op    (op),
                .funct (funct),
                .kind  (kind)
        );

        ctrl_sequencer u_sequencer (
                .clk      (clk),
                .reset    (reset),
                .kind     (kind),
                .overflow (overflow),
                .eq       (eq),
                .state    (state),
                .step     (step)
        );

        ctrl_outputs u_outputs (
                .state           (state),
                .step            (step),
                .pc_src          (pc_src),
                .alu_src_a       (alu_src_a),
                .alu_src_b       (alu_src_b),
                .alu_op          (alu_op),
                .iord            (iord),
                .load_ctrl       (load_ctrl),
                .bank_write_reg  (bank_write_reg),
                .bank_write_data (bank_write_data),
                .wr              (wr),
                .ir_write        (ir_write),
                .pc_write        (pc_write),
                .bank_write      (bank_write),
                .epc_write       (epc_write),
                .a_write         (a_write),
                .b_write         (b_write),
                .alu_out_write   (alu_out_write),
                .mem_reg_write   (mem_reg_write)
        );

endmodule

`default_nettype wire

//--- mips_control.f
+incdir+design
design/ctrl_pkg.sv
design/ctrl_decode.sv
design/ctrl_sequencer.sv
design/ctrl_outputs.sv
design/mips_control.sv
verif/mips_control_asserts.sv
verif/mips_control_tb.sv

//--- verif/mips_control_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mips_control_asserts (
        input wire                  clk,
        input wire                  reset,
        input wire                  ir_write,
        input wire                  pc_write,
        input wire                  bank_write,
        input wire                  wr,
        input wire                  epc_write,
        input wire ctrl_pkg::iord_e iord
);
        import ctrl_pkg::*;

        // Loading the IR always advances the PC
        ir_with_pc: assert property (@(posedge clk) disable iff (reset)
                ir_write |-> pc_write)
                else $error("ir_write asserted without pc_write");

        no_bank_write_on_store: assert property (@(posedge clk) disable iff (reset)
                !(bank_write && wr))
                else $error("bank_write and memory write high in the same cycle");

        epc_on_vector: assert property (@(posedge clk) disable iff (reset)
                epc_write |-> (iord == IORD_EXC_ILLEGAL || iord == IORD_EXC_OVERFLOW))
                else $error("epc_write while iord %0d is no exception vector", iord);

endmodule

`default_nettype wire

//--- verif/mips_control_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_defs.svh"

module mips_control_tb;
        import ctrl_pkg::*;

        logic           clk;
        logic           reset;
        op_e            op;
        funct_e         funct;
        logic           overflow;
        logic           eq;
        pc_src_e        pc_src;
        a_src_e         alu_src_a;
        b_src_e         alu_src_b;
        alu_op_e        alu_op;
        iord_e          iord;
        load_size_e     load_ctrl;
        reg_dst_e       bank_write_reg;
        reg_data_e      bank_write_data;
        logic           wr;
        logic           ir_write;
        logic           pc_write;
        logic           bank_write;
        logic           epc_write;
        logic           a_write;
        logic           b_write;
        logic           alu_out_write;
        logic           mem_reg_write;

        int             errors;
        int             cyc;            // Cycles since the ir_write of this instruction
        logic [7:0]     lfsr;

        mips_control u_mips_control (.*);

        bind mips_control mips_control_asserts u_asserts (
                .clk        (clk),
                .reset      (reset),
                .ir_write   (ir_write),
                .pc_write   (pc_write),
                .bank_write (bank_write),
                .wr         (wr),
                .epc_write  (epc_write),
                .iord       (iord)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
                assert (exp === act) else begin
                        errors++;
                        $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
                end
        endtask

        task automatic advance_to(input int k);
                while (cyc < k) begin
                        @(negedge clk);
                        cyc++;
                end
        endtask

        // Counts cycles to the next ir_write and gives -1 on timeout
        task automatic wait_ir_write(input int limit, output int n);
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                end while (!ir_write && n < limit);
                if (!ir_write)
                        n = -1;
        endtask

        task automatic next_fetch(input int exp);
                int n;
                wait_ir_write(40, n);
                assert (n >= 0) else begin
                        errors++;
                        $display("Timeout: no instruction fetch within 40 cycles");
                end
                if (n >= 0)
                        check("ir_write cycle", 8'(exp), 8'(n));
        endtask

        // IR load happens at the edge after ir_write, like the real register
        task automatic issue(input op_e o, input funct_e f, input logic ovf, input logic e);
                @(posedge clk);
                op       <= o;
                funct    <= f;
                overflow <= ovf;
                eq       <= e;
                cyc = 0;
                advance_to(1);
                check("a_write", 8'd1, 8'(a_write));
                check("b_write", 8'd1, 8'(b_write));
        endtask

        task automatic check_fetch();
                repeat (`CTRL_FETCH_STEPS) begin
                        @(negedge clk);
                        check("wr", 8'd0, 8'(wr));
                        check("iord", 8'(IORD_PC), 8'(iord));
                        check("alu_op", 8'(ALU_ADD), 8'(alu_op));
                        check("alu_src_a", 8'(A_SRC_PC), 8'(alu_src_a));
                        check("alu_src_b", 8'(B_SRC_FOUR), 8'(alu_src_b));
                        check("ir_write", 8'd0, 8'(ir_write));
                end
                @(negedge clk);
                check("ir_write", 8'd1, 8'(ir_write));
                check("pc_write", 8'd1, 8'(pc_write));
        endtask

        // Reset is already high here and stays for one more edge
        task automatic reset_dut();
                @(negedge clk);
                check("wr", 8'd0, 8'(wr));
                check("write enables", 8'd0, {ir_write, pc_write, bank_write, epc_write,
                        a_write, b_write, alu_out_write, mem_reg_write});
                @(posedge clk);
                reset <= 1'b0;
                check_fetch();
        endtask

        function automatic logic lfsr_bit();
                lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                return lfsr[0];
        endfunction

        function automatic logic is_known_opcode(input logic [5:0] code);
                return code inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h09,
                        6'h23, 6'h2B};
        endfunction

        function automatic logic [5:0] draw_opcode();
                logic [5:0] code;
                do begin
                        code = '0;
                        repeat (6) code = {code[4:0], lfsr_bit()};
                end while (is_known_opcode(code));
                return code;
        endfunction

        task automatic check_exception(input iord_e vec, input int start);
                for (int k = start; k < start + `CTRL_EXC_STEPS; k++) begin
                        advance_to(k);
                        check("epc_write", 8'd1, 8'(epc_write));
                        check("iord", 8'(vec), 8'(iord));
                        check("bank_write", 8'd0, 8'(bank_write));
                end
                advance_to(start + `CTRL_EXC_STEPS);
                check("pc_write", 8'd1, 8'(pc_write));
                check("pc_src", 8'(PC_SRC_EXC_LOAD), 8'(pc_src));
                check("load_ctrl", 8'(LOAD_BYTE), 8'(load_ctrl));
        endtask

        task automatic test_rtype(input funct_e f, input alu_op_e exp_op, input logic ovf);
                logic trap;
                trap = ovf && (f != FN_AND);
                issue(OP_RTYPE, f, ovf, 1'b0);
                advance_to(3);
                check("alu_op", 8'(exp_op), 8'(alu_op));
                check("alu_src_a", 8'(A_SRC_A), 8'(alu_src_a));
                check("alu_out_write", 8'd1, 8'(alu_out_write));
                if (trap) begin
                        check_exception(IORD_EXC_OVERFLOW, 4);
                end else begin
                        advance_to(4);
                        check("bank_write", 8'd1, 8'(bank_write));
                        check("bank_write_reg", 8'(REG_DST_RD), 8'(bank_write_reg));
                        check("bank_write_data", 8'(REG_DATA_ALU_OUT), 8'(bank_write_data));
                end
                next_fetch(`CTRL_FETCH_STEPS + 1);
        endtask

        task automatic test_immediate(input op_e o, input logic ovf);
                issue(o, FN_ADD, ovf, 1'b0);
                advance_to(3);
                check("alu_src_b", 8'(B_SRC_IMM), 8'(alu_src_b));
                if (o == OP_ADDI && ovf) begin
                        check_exception(IORD_EXC_OVERFLOW, 4);
                end else begin
                        advance_to(4);
                        check("bank_write", 8'd1, 8'(bank_write));
                        check("bank_write_reg", 8'(REG_DST_RT), 8'(bank_write_reg));
                end
                next_fetch(`CTRL_FETCH_STEPS + 1);
        endtask

        task automatic test_branch(input op_e o, input logic e);
                logic taken;
                taken = (o == OP_BEQ) ? e : !e;
                issue(o, FN_ADD, 1'b0, e);
                advance_to(3);
                check("alu_op", 8'(ALU_CMP), 8'(alu_op));
                check("pc_write", 8'd0, 8'(pc_write));
                advance_to(4);
                check("pc_write", 8'(taken), 8'(pc_write));
                if (taken)
                        check("pc_src", 8'(PC_SRC_ALU_OUT), 8'(pc_src));
                // Not taken means fetch already started at cycle 4
                next_fetch(taken ? `CTRL_FETCH_STEPS + 1 : `CTRL_FETCH_STEPS);
        endtask

        task automatic test_jump(input logic link);
                issue(link ? OP_JAL : OP_J, FN_ADD, 1'b0, 1'b0);
                if (link) begin
                        advance_to(3);
                        check("bank_write", 8'd1, 8'(bank_write));
                        check("bank_write_reg", 8'(REG_DST_RA), 8'(bank_write_reg));
                        check("bank_write_data", 8'(REG_DATA_PC), 8'(bank_write_data));
                end
                advance_to(link ? 4 : 3);
                check("pc_write", 8'd1, 8'(pc_write));
                check("pc_src", 8'(PC_SRC_JUMP), 8'(pc_src));
                next_fetch(`CTRL_FETCH_STEPS + 1);
        endtask

        task automatic test_memory(input logic store);
                issue(store ? OP_SW : OP_LW, FN_ADD, 1'b0, 1'b0);
                advance_to(3);
                check("alu_out_write", 8'd1, 8'(alu_out_write));
                check("alu_src_b", 8'(B_SRC_IMM), 8'(alu_src_b));
                for (int k = 4; k <= 6; k++) begin
                        advance_to(k);
                        check("iord", 8'(IORD_ALU_OUT), 8'(iord));
                        check("wr", 8'd0, 8'(wr));
                        check("mem_reg_write", 8'(k == 6), 8'(mem_reg_write));
                end
                advance_to(7);
                check("wr", 8'(store), 8'(wr));
                check("bank_write", 8'(!store), 8'(bank_write));
                if (store)
                        check("iord", 8'(IORD_ALU_OUT), 8'(iord));
                else
                        check("bank_write_data", 8'(REG_DATA_MEM), 8'(bank_write_data));
                next_fetch(`CTRL_FETCH_STEPS + 1);
        endtask

        task automatic test_illegal();
                issue(op_e'(draw_opcode()), FN_ADD, 1'b0, 1'b0);
                check_exception(IORD_EXC_ILLEGAL, 3);
                next_fetch(`CTRL_FETCH_STEPS + 1);
        endtask

        task automatic test_break();
                int n;
                issue(OP_RTYPE, FN_BREAK, 1'b0, 1'b0);
                wait_ir_write(20, n);
                assert (n < 0) else begin
                        errors++;
                        $display("BREAK did not halt, an instruction fetch followed");
                end
                @(posedge clk);
                reset <= 1'b1;
                @(posedge clk);
                reset_dut();
        endtask

        initial begin
                errors   = 0;
                cyc      = 0;
                lfsr     = 8'd96;
                reset    = 1'b1;
                op       = OP_RTYPE;
                funct    = FN_ADD;
                overflow = 1'b0;
                eq       = 1'b0;
                reset_dut();
                test_rtype(FN_ADD, ALU_ADD, 1'b0);
                test_rtype(FN_SUB, ALU_SUB, 1'b0);
                test_rtype(FN_AND, ALU_AND, 1'b0);
                test_rtype(FN_ADD, ALU_ADD, 1'b1);
                test_immediate(OP_ADDI, 1'b0);
                test_immediate(OP_ADDI, 1'b1);
                test_immediate(OP_ADDIU, 1'b1);
                test_branch(OP_BEQ, 1'b1);
                test_branch(OP_BEQ, 1'b0);
                test_branch(OP_BNE, 1'b1);
                test_branch(OP_BNE, 1'b0);
                test_jump(1'b0);
                test_jump(1'b1);
                test_memory(1'b0);
                test_memory(1'b1);
                test_illegal();
                test_illegal();
                test_break();
                $display("Error count: %0d", errors);
                if (errors == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

`default_nettype wire
